// ==== awg_write.f ====
+incdir+sim
hdl/awg_pkg.sv
hdl/awg_burst_reg.sv
hdl/awg_addr_calc.sv
hdl/awg_beat_ctrl.sv
hdl/awg_write_top.sv
sim/awg_write_tb.sv

// ==== hdl/awg_addr_calc.sv ====
// Beat address calculator
// Next-beat address for FIXED, INCR and WRAP bursts, purely combinational

`timescale 1ns/1ps
`default_nettype none

module awg_addr_calc
  import awg_pkg::*;
(
  input  aw_cmd_t active_cmd,             // Command of the open burst
  input  addr_t   beat_bytes,             // Bytes per beat
  input  addr_t   wrap_mask,              // Wrap container size minus one
  input  logic    first_beat,             // Beat 0 of a burst
  input  addr_t   prev_addr,              // Address of the last registered beat
  output addr_t   beat_addr
);

  addr_t align_mask;                      // Clears the byte offset inside a beat
  addr_t start_aligned;                   // A
  addr_t step_addr;                       // Previous address plus one beat
  addr_t wrap_base;                       // B, lowest address of the container
  addr_t wrap_fold;                       // Step folded back into the container
  addr_t incr_addr;
  addr_t wrap_addr;

  //////////////////////////////////////////////////
  // Start alignment
  //////////////////////////////////////////////////

  // beat_bytes is a power of two so the mask is a run of ones
  assign align_mask    = ~(beat_bytes - addr_t'(1));
  assign start_aligned = active_cmd.addr & align_mask;

  // Previous beat is already aligned after beat 0
  assign step_addr = prev_addr + beat_bytes;

  //////////////////////////////////////////////////
  // Wrap boundary
  //////////////////////////////////////////////////

  // Container is a power of two sized block holding the aligned start
  assign wrap_base = start_aligned & ~wrap_mask;

  // Carry out of the container is dropped and the base put back
  assign wrap_fold = wrap_base | (step_addr & wrap_mask);

  //////////////////////////////////////////////////
  // Per-burst results
  //////////////////////////////////////////////////

  assign incr_addr = first_beat ? start_aligned : step_addr;
  assign wrap_addr = first_beat ? start_aligned : wrap_fold;

  // Burst type select
  always_comb
  begin
    case (active_cmd.burst)
      BURST_FIXED:
      begin
        beat_addr = active_cmd.addr;      // Unaligned start on every beat
      end
      BURST_WRAP:
      begin
        beat_addr = wrap_addr;
      end
      default:
      begin
        beat_addr = incr_addr;            // INCR, RSVD is trapped upstream
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/awg_beat_ctrl.sv ====
// Beat controller
// Burst FSM, beat counter, FIFO pop and registered output beat to the slave

`timescale 1ns/1ps
`default_nettype none

module awg_beat_ctrl
  import awg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     wvalid,                // Master beat present
  input  logic     wlast,                 // Master marks last beat
  input  logic     slave_ready,           // Slave can take a beat
  input  data_t    wdata,
  input  strb_t    wstrb,
  input  prot_t    prot,                  // From the active command
  input  len_t     burst_len,             // Beats minus one
  input  addr_t    beat_addr,             // Computed address of this beat
  output logic     beat_accept,
  output logic     first_beat,
  output logic     cmd_pop,               // One-cycle pulse to the command FIFO
  output logic     wr_valid,
  output wr_beat_t wr_beat
);

  beat_state_e state_q;
  beat_state_e state_d;
  len_t        beat_cnt;                  // Beats already taken in this burst
  logic        last_beat;

  //////////////////////////////////////////////////
  // Accept and burst position
  //////////////////////////////////////////////////

  // Master ready mirrors slave ready, so both must be high
  assign beat_accept = wvalid & slave_ready;
  assign first_beat  = (state_q == IDLE);
  assign last_beat   = (beat_cnt == burst_len);

  // FIFO advances on the edge that ends the accept cycle
  assign cmd_pop = beat_accept & last_beat;

  //////////////////////////////////////////////////
  // Burst FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    if (beat_accept)
    begin
      state_d = last_beat ? IDLE : BURST;   // Single-beat burst stays in IDLE
    end
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Beat counter, moves on accept edges only
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      beat_cnt <= '0;
    end
    else if (beat_accept)
    begin
      if (last_beat)
      begin
        beat_cnt <= '0;                   // Ready for the next command
      end
      else
      begin
        beat_cnt <= beat_cnt + len_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Output beat register
  //////////////////////////////////////////////////

  // Valid follows the master only when the slave is free
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      wr_valid <= 1'b0;
    end
    else if (slave_ready)
    begin
      wr_valid <= wvalid;
    end
  end

  // Payload loads on accept and holds through a stall
  always_ff @(posedge clk)
  begin
    if (beat_accept)
    begin
      wr_beat.addr <= beat_addr;
      wr_beat.data <= wdata;
      wr_beat.strb <= wstrb;
      wr_beat.prot <= prot;
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // Master's last flag must match the command's beat count
  a_wlast_match: assert property (@(posedge clk) disable iff (!reset)
    beat_accept |-> (wlast == last_beat))
    else $error("wlast disagrees with burst length");

endmodule

`default_nettype wire

// ==== hdl/awg_burst_reg.sv ====
// Burst command register
// Holds the open burst's command and decodes beat size and wrap container

`timescale 1ns/1ps
`default_nettype none

module awg_burst_reg
  import awg_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    beat_accept,            // Beat taken this cycle
  input  logic    first_beat,             // No burst open yet
  input  aw_cmd_t cmd_head,               // FIFO head
  output aw_cmd_t active_cmd,
  output addr_t   beat_bytes,             // Bytes per beat
  output addr_t   wrap_mask               // Wrap container size minus one
);

  aw_cmd_t cmd_q;                         // Copy of the open burst's command
  size_t   eff_size;                      // Size code clamped to the data bus
  addr_t   beat_total;                    // Bytes in the whole burst

  //////////////////////////////////////////////////
  // Command latch
  //////////////////////////////////////////////////

  // Head is captured with the first beat, FIFO may advance afterwards
  always_ff @(posedge clk)
  begin
    if (beat_accept && first_beat)
    begin
      cmd_q <= cmd_head;
    end
  end

  // First beat steers straight from the head
  assign active_cmd = first_beat ? cmd_head : cmd_q;

  //////////////////////////////////////////////////
  // Size and container decode
  //////////////////////////////////////////////////

  assign eff_size = (active_cmd.size > size_t'(MAX_SIZE)) ? size_t'(MAX_SIZE)
                                                           : active_cmd.size;

  assign beat_bytes = addr_t'(1) << eff_size;                      // 1, 2 or 4
  assign beat_total = (addr_t'(active_cmd.len) + addr_t'(1)) << eff_size;
  assign wrap_mask  = beat_total - addr_t'(1);  // Power of two for legal WRAP

  //////////////////////////////////////////////////
  // Command checks
  //////////////////////////////////////////////////

  // Beat wider than the data bus cannot be carried
  a_size_fits: assert property (@(posedge clk) disable iff (!reset)
    beat_accept |-> active_cmd.size <= size_t'(MAX_SIZE))
    else $error("burst size code above data width");

  // Reserved burst type has no address rule
  a_no_rsvd: assert property (@(posedge clk) disable iff (!reset)
    beat_accept |-> active_cmd.burst != BURST_RSVD)
    else $error("reserved burst type accepted");

  // WRAP needs 2, 4, 8 or 16 beats
  a_wrap_len: assert property (@(posedge clk) disable iff (!reset)
    (beat_accept && active_cmd.burst == BURST_WRAP) |->
      active_cmd.len inside {len_t'(1), len_t'(3), len_t'(7), len_t'(15)})
    else $error("illegal WRAP burst length");

endmodule

`default_nettype wire

// ==== hdl/awg_pkg.sv ====
// Write address generator shared definitions
// Bus widths, payload types, command and beat structs, FSM encodings

`default_nettype none

package awg_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int ADDR_W   = 32;           // Byte address
  localparam int DATA_W   = 32;           // Write data bus
  localparam int STRB_W   = DATA_W / 8;   // One strobe per data byte
  localparam int LEN_W    = 8;            // AXI beat count minus one
  localparam int SIZE_W   = 3;            // AXI size code
  localparam int PROT_W   = 3;            // AXI protection bits
  localparam int MAX_SIZE = 2;            // 4 bytes per beat fills the data bus

  //////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [LEN_W-1:0]  len_t;       // Beats in burst minus one
  typedef logic [SIZE_W-1:0] size_t;      // log2 of bytes per beat
  typedef logic [PROT_W-1:0] prot_t;

  // AXI burst type encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,                  // Same address every beat
    BURST_INCR  = 2'b01,                  // Step by beat size
    BURST_WRAP  = 2'b10,                  // Step and fold inside container
    BURST_RSVD  = 2'b11                   // Not allowed on this port
  } burst_e;

  //////////////////////////////////////////////////
  // Command and beat payloads
  //////////////////////////////////////////////////

  // Command at the FIFO head
  typedef struct packed {
    addr_t  addr;                         // Start address, may be unaligned
    len_t   len;
    size_t  size;
    burst_e burst;
    prot_t  prot;
  } aw_cmd_t;

  // Beat handed to the slave
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
    prot_t prot;
  } wr_beat_t;

  // Burst tracking FSM
  typedef enum logic {
    IDLE,                                 // No burst open, next beat is a first beat
    BURST                                 // Burst open after its first beat
  } beat_state_e;

endpackage

`default_nettype wire

// ==== hdl/awg_write_top.sv ====
// Write address generator top level
// Joins the command register, address calculator and beat controller

`timescale 1ns/1ps
`default_nettype none

module awg_write_top
  import awg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  aw_cmd_t  cmd_head,              // FIFO head, valid while a burst waits
  output logic     cmd_pop,
  input  logic     wvalid,
  input  data_t    wdata,
  input  strb_t    wstrb,
  input  logic     wlast,
  output logic     wready,
  output wr_beat_t wr_beat,
  output logic     wr_valid,
  input  logic     slave_ready
);

  logic    beat_accept;
  logic    first_beat;
  aw_cmd_t active_cmd;
  addr_t   beat_bytes;
  addr_t   wrap_mask;
  addr_t   beat_addr;

  // No buffering on the data path, master sees slave ready directly
  assign wready = slave_ready;

  awg_burst_reg awg_burst_reg_i (
    .clk         (clk),
    .reset       (reset),
    .beat_accept (beat_accept),
    .first_beat  (first_beat),
    .cmd_head    (cmd_head),
    .active_cmd  (active_cmd),
    .beat_bytes  (beat_bytes),
    .wrap_mask   (wrap_mask)
  );

  awg_addr_calc awg_addr_calc_i (
    .active_cmd (active_cmd),
    .beat_bytes (beat_bytes),
    .wrap_mask  (wrap_mask),
    .first_beat (first_beat),
    .prev_addr  (wr_beat.addr),           // Registered address feeds back
    .beat_addr  (beat_addr)
  );

  awg_beat_ctrl awg_beat_ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .wvalid      (wvalid),
    .wlast       (wlast),
    .slave_ready (slave_ready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .prot        (active_cmd.prot),
    .burst_len   (active_cmd.len),
    .beat_addr   (beat_addr),
    .beat_accept (beat_accept),
    .first_beat  (first_beat),
    .cmd_pop     (cmd_pop),
    .wr_valid    (wr_valid),
    .wr_beat     (wr_beat)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the write address generator testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f awg_write.f \
  --top-module awg_write_tb -o awg_write_sim \
  && ./obj_dir/awg_write_sim | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }

grep -q "All tests passed!" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

// ==== sim/awg_write_tasks.svh ====
// Write address generator test tasks
// Address model, compare tasks, beat drivers and the directed tests

`ifndef AWG_WRITE_TASKS_SVH
`define AWG_WRITE_TASKS_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Address of beat n straight from the burst rules
function automatic addr_t model_addr(input aw_cmd_t cmd, input int n);
  addr_t bytes;
  addr_t a;
  addr_t c;
  addr_t b;
  addr_t off;
  bytes = addr_t'(1) << cmd.size;
  a = cmd.addr - (cmd.addr % bytes);                 // Aligned start
  c = bytes * (addr_t'(cmd.len) + addr_t'(1));       // Container size
  b = a - (a % c);                                   // Container base
  off = addr_t'(n) * bytes;
  case (cmd.burst)
    BURST_FIXED: return cmd.addr;
    BURST_WRAP:  return b + ((a - b + off) % c);
    default:     return a + off;
  endcase
endfunction

// Legal command, WRAP gets 2, 4, 8 or 16 beats
function automatic aw_cmd_t random_cmd();
  aw_cmd_t c;
  int      pick;
  c.addr = addr_t'($random(seed));
  c.size = size_t'($unsigned($random(seed)) % 3);
  c.prot = prot_t'($random(seed));
  pick = int'($unsigned($random(seed)) % 3);
  c.burst = burst_e'(2'(pick));
  if (c.burst == BURST_WRAP)
  begin
    c.len = len_t'((2 << ($unsigned($random(seed)) % 4)) - 1);
  end
  else
  begin
    c.len = len_t'($unsigned($random(seed)) % 8);   // Up to 8 beats
  end
  return c;
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic compare_beat(input wr_beat_t expected, input wr_beat_t actual);
  if (actual !== expected)
  begin
    $display("mismatch %s: beat expected addr=%h data=%h strb=%h prot=%h", test_name,
             expected.addr, expected.data, expected.strb, expected.prot);
    $display("  actual addr=%h data=%h strb=%h prot=%h",
             actual.addr, actual.data, actual.strb, actual.prot);
    fail_stop("beat at the slave is wrong");
  end
endtask

task automatic compare_pop(input string what, input logic expected, input logic actual);
  if (actual !== expected)
  begin
    $display("mismatch %s: %s expected %b actual %b", test_name, what, expected, actual);
    fail_stop("control output is wrong");
  end
endtask

//////////////////////////////////////////////////
// Drivers
//////////////////////////////////////////////////

// One beat, repeated on stall cycles until accepted
task automatic send_beat(input aw_cmd_t cmd, input int n, input logic stall);
  wr_beat_t exp;
  data_t    d;
  strb_t    s;
  logic     ready;
  logic     taken;
  d = data_t'({burst_id[15:0], 16'(n)}) ^ 32'hC3A5_0F00;
  s = ~strb_t'(n);
  exp.addr = model_addr(cmd, n);
  exp.data = d;
  exp.strb = s;
  exp.prot = cmd.prot;
  exp_q.push_back(exp);
  sent_count++;
  taken = 1'b0;
  while (!taken)
  begin
    @(negedge clk);
    ready = stall ? (($random(seed) & 3) != 0) : 1'b1;    // About one stall in four
    cmd_head = cmd;
    wvalid = 1'b1;
    wdata = d;
    wstrb = s;
    wlast = (len_t'(n) == cmd.len);
    slave_ready = ready;
    #(CLK_PERIOD / 4);                                     // Combinational outputs settled
    compare_pop("wready", ready, wready);
    compare_pop("cmd_pop", ready && wlast, cmd_pop);       // Only on the last accept
    @(posedge clk);
    taken = ready;
  end
endtask

task automatic run_burst(input aw_cmd_t cmd, input logic stall);
  for (int n = 0; n <= int'(cmd.len); n++)
  begin
    send_beat(cmd, n, stall);
  end
  burst_id++;
endtask

// Master idle until the slave has taken everything
task automatic drain_beats();
  int guard;
  guard = 0;
  @(negedge clk);
  wvalid = 1'b0;
  wlast = 1'b0;
  slave_ready = 1'b1;
  while (exp_q.size() != 0 && guard < 8)
  begin
    @(negedge clk);
    compare_pop("cmd_pop", 1'b0, cmd_pop);
    guard++;
  end
  if (exp_q.size() != 0)
  begin
    fail_stop("beats still outstanding after the slave was left ready");
  end
  compare_pop("wr_valid", 1'b0, wr_valid);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

// Beat offered during reset must not show up as valid
task automatic test_reset_state();
  test_name = "reset_state";
  #(CLK_PERIOD / 4);
  compare_pop("wr_valid", 1'b0, wr_valid);
  compare_pop("cmd_pop", 1'b0, cmd_pop);
endtask

task automatic test_incr_unaligned();
  aw_cmd_t cmd;
  test_name = "incr_unaligned";
  cmd = '{addr: 32'h0000_1006, len: 8'd3, size: 3'd2, burst: BURST_INCR, prot: 3'b101};
  run_burst(cmd, 1'b0);                 // 1004, 1008, 100C, 1010
  drain_beats();
endtask

task automatic test_wrap_middle();
  aw_cmd_t cmd;
  test_name = "wrap_middle";
  cmd = '{addr: 32'h0000_1008, len: 8'd3, size: 3'd2, burst: BURST_WRAP, prot: 3'b010};
  run_burst(cmd, 1'b0);                 // Folds to 1000 after 100C
  drain_beats();
endtask

task automatic test_fixed_repeat();
  aw_cmd_t cmd;
  test_name = "fixed_repeat";
  cmd = '{addr: 32'h0000_2003, len: 8'd2, size: 3'd2, burst: BURST_FIXED, prot: 3'b001};
  run_burst(cmd, 1'b0);
  drain_beats();
endtask

// Back-to-back bursts under random slave stalls
task automatic test_random_stream();
  aw_cmd_t cmd;
  test_name = "random_stream";
  for (int i = 0; i < RAND_BURSTS; i++)
  begin
    cmd = random_cmd();
    run_burst(cmd, 1'b1);
  end
  drain_beats();
endtask

`endif

// ==== sim/awg_write_tb.sv ====
// Write address generator testbench
// Clock, reset, DUT, slave-side monitor, watchdog and the directed test sequence

`timescale 1ns/1ps
`default_nettype none

module awg_write_tb
  import awg_pkg::*;
();

  localparam int CLK_PERIOD  = 100;                          // ns
  localparam int RAND_BURSTS = 24;                           // Bursts in the stream test
  localparam int MAX_BEATS   = 11 + RAND_BURSTS * 16 + 10;   // Directed, random, slack
  localparam int WATCHDOG_NS = MAX_BEATS * 20 * CLK_PERIOD;

  logic     clk;
  logic     reset;
  aw_cmd_t  cmd_head;
  logic     cmd_pop;
  logic     wvalid;
  data_t    wdata;
  strb_t    wstrb;
  logic     wlast;
  logic     wready;
  wr_beat_t wr_beat;
  logic     wr_valid;
  logic     slave_ready;

  int       seed = 6;                    // Stall and command stream
  int       burst_id = 0;                // Tags data of each burst
  int       sent_count = 0;
  int       taken_count = 0;
  string    test_name = "none";
  wr_beat_t exp_q[$];                    // Beats sent but not yet taken by the slave
  wr_beat_t exp_beat;

  // Stop at the first error
  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  `include "awg_write_tasks.svh"

  //////////////////////////////////////////////////
  // Clock, DUT, monitor, watchdog
  //////////////////////////////////////////////////

  always #(CLK_PERIOD / 2) clk = ~clk;

  awg_write_top awg_write_top_i (
    .clk         (clk),
    .reset       (reset),
    .cmd_head    (cmd_head),
    .cmd_pop     (cmd_pop),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wlast       (wlast),
    .wready      (wready),
    .wr_beat     (wr_beat),
    .wr_valid    (wr_valid),
    .slave_ready (slave_ready)
  );

  // Slave takes a beat on an edge with valid and ready high
  always @(posedge clk)
  begin
    if (reset && wr_valid && slave_ready)
    begin
      if (exp_q.size() == 0)
      begin
        fail_stop("slave took a beat that was never sent");
      end
      else
      begin
        exp_beat = exp_q.pop_front();    // Oldest outstanding beat
        compare_beat(exp_beat, wr_beat);
        taken_count++;
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_stop("watchdog timeout, beats stopped reaching the slave");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    reset = 1'b0;                        // Held low for 3 cycles
    cmd_head = '0;
    wvalid = 1'b1;                       // Master already presenting a beat in reset
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    slave_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    wvalid = 1'b0;
    test_reset_state();
    test_incr_unaligned();
    test_wrap_middle();
    test_fixed_repeat();
    test_random_stream();
    if (exp_q.size() == 0 && taken_count == sent_count)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      fail_stop("beats taken by the slave differ from beats sent");
    end
  end

endmodule

`default_nettype wire
